// ==== Makefile ====
# Verilator build of the serial calculator testbench

SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = tb_serial_calc
FILELIST = verilog.f
BUILD    = obj_dir
SOURCES  = $(wildcard hdl/*.sv) $(wildcard dv/*.sv)
BIN      = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuild only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

// ==== dv/tb_serial_calc.sv ====
// ----------------------------------------------------------
// serial calculator testbench
// table-driven byte stimulus, reference model for tx bytes
// and led values, back-pressure stalls and a cycle timeout
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_serial_calc;

   logic              CLKOP = 1'b0;
   logic              i_rst;
   calc_pkg::byte_t   i_rx_data;
   logic              i_rx_valid;
   logic              i_tx_ready;
   calc_pkg::byte_t   o_tx_data;
   logic              o_tx_valid;
   calc_pkg::led_t    o_led;

   // stimulus table with one entry per received byte
   string             tab_name[$];
   calc_pkg::byte_t   tab_byte[$];
   int                tab_idle[$];     // extra cycles after the step
   bit                tab_stall[$];    // random tx stall on this byte
   calc_pkg::led_t    tab_led[$];

   // reference model state
   int                m_state;         // 0 r1, 1 r2, 2 operator
   logic [3:0]        m_r1;
   logic [3:0]        m_r2;
   logic [4:0]        m_res;
   int                m_sel;           // 0 result, 1 cr, 2 del
   calc_pkg::led_t    m_led;
   calc_pkg::byte_t   exp_q[$];        // expected tx characters in order
   string             exp_name[$];

   int                cycles;
   int                limit;

   serial_calc_top DUT (
      .CLKOP      (CLKOP),
      .i_rst      (i_rst),
      .i_rx_data  (i_rx_data),
      .i_rx_valid (i_rx_valid),
      .i_tx_ready (i_tx_ready),
      .o_tx_data  (o_tx_data),
      .o_tx_valid (o_tx_valid),
      .o_led      (o_led)
   );

   always #5 CLKOP = ~CLKOP;   // 100 MHz

   // ----------------------------------------------------------
   // error reporting
   // ----------------------------------------------------------
   task automatic fail_value(input string name, input logic [7:0] exp, input logic [7:0] act);
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("Errors found");
      $fatal(1, "stopping at first error");
   endtask

   task automatic fail_text(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "stopping at first error");
   endtask

   task automatic add_step(input string name, input calc_pkg::byte_t b, input int idle,
                           input bit stall, input calc_pkg::led_t led);
      tab_name.push_back(name);
      tab_byte.push_back(b);
      tab_idle.push_back(idle);
      tab_stall.push_back(stall);
      tab_led.push_back(led);
   endtask

   // ----------------------------------------------------------
   // reference model applying the calculator rules per byte
   // ----------------------------------------------------------
   task automatic model_byte(input string name, input calc_pkg::byte_t b);
      logic is_digit;
      is_digit = (b[7:4] == calc_pkg::DIGIT_CLASS);
      if (b == calc_pkg::CHAR_ESC) begin
         m_state = 0;                 // soft clear with no echo
         m_r1    = 4'h0;
         m_r2    = 4'h0;
         m_res   = 5'h00;
         m_sel   = 0;
      end else begin
         exp_q.push_back(b);          // echo first
         exp_name.push_back(name);
         m_sel = (b == calc_pkg::CHAR_CR) ? 1 : (b == calc_pkg::CHAR_DEL) ? 2 : 0;
         case (m_state)
            0: begin
               if (is_digit) begin
                  m_r1    = b[3:0];
                  m_state = 1;
               end
            end
            1: begin
               if (is_digit) begin
                  m_r2    = b[3:0];
                  m_state = 2;
               end else begin
                  m_state = 0;
               end
            end
            default: begin
               if (b == calc_pkg::CHAR_PLUS) m_res = 5'(int'(m_r1) + int'(m_r2));
               if (b == calc_pkg::CHAR_MINUS) m_res = 5'(32'd16 + m_r1 - m_r2);  // carry = no borrow
               if (b == calc_pkg::CHAR_PLUS || b == calc_pkg::CHAR_MINUS) begin
                  exp_q.push_back(calc_pkg::RESULT_BASE + m_res);
                  exp_name.push_back(name);
               end
               m_state = 0;
            end
         endcase
      end
      m_led = (m_sel == 1) ? {1'b0, m_r1} : (m_sel == 2) ? {1'b0, m_r2} : m_res;
   endtask

   task automatic check_led(input int idx);
      assert (m_led == tab_led[idx])
         else fail_value({tab_name[idx], " table"}, {3'b000, tab_led[idx]}, {3'b000, m_led});
      assert (o_led == m_led)
         else fail_value(tab_name[idx], {3'b000, m_led}, {3'b000, o_led});
   endtask

   // send one byte and wait for echo, result and led to settle
   task automatic apply_step(input int idx);
      int hold;
      int stall_len;
      int c;
      stall_len = 0;
      if (tab_stall[idx]) stall_len = 5 + int'($urandom % 16);   // 5 to 20 cycles
      hold = 7 + stall_len + tab_idle[idx];
      @(posedge CLKOP);
      i_rx_data  <= tab_byte[idx];
      i_rx_valid <= 1'b1;
      if (stall_len != 0) i_tx_ready <= 1'b0;
      model_byte(tab_name[idx], tab_byte[idx]);
      for (c = 1; c < hold; c++) begin
         @(posedge CLKOP);
         if (c == 1) i_rx_valid <= 1'b0;
         if (c == stall_len) i_tx_ready <= 1'b1;   // release back-pressure
         if (c == 6) check_led(idx);
      end
   endtask

   // ----------------------------------------------------------
   // tx monitor compares every sent byte with the queue head
   // ----------------------------------------------------------
   always @(posedge CLKOP) begin
      if (o_tx_valid) begin
         assert (i_tx_ready) else fail_text("tx byte sent while i_tx_ready was low");
         assert (exp_q.size() > 0) else fail_text("tx byte sent with none expected");
         assert (o_tx_data == exp_q[0]) else fail_value(exp_name[0], exp_q[0], o_tx_data);
         void'(exp_q.pop_front());
         void'(exp_name.pop_front());
      end
   end

   // run limit from table length
   always @(posedge CLKOP) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         $display("run timed out after %0d cycles", cycles);
         $display("Errors found");
         $fatal(1, "timeout");
      end
   end

   initial begin
      i_rst      = 1'b1;
      i_rx_data  = 8'h00;
      i_rx_valid = 1'b0;
      i_tx_ready = 1'b1;
      cycles     = 0;
      m_state    = 0;
      m_r1       = 4'h0;
      m_r2       = 4'h0;
      m_res      = 5'h00;
      m_sel      = 0;
      m_led      = 5'h00;
      void'($urandom(32'h0ad1e89c));

      // addition plain and with carry
      add_step("add_35", "3", 0, 1'b0, 5'h00);
      add_step("add_35", "5", 0, 1'b0, 5'h00);
      add_step("add_35", "+", 2, 1'b0, 5'h08);
      add_step("add_99", "9", 0, 1'b0, 5'h08);
      add_step("add_99", "9", 0, 1'b0, 5'h08);
      add_step("add_99", "+", 2, 1'b0, 5'h12);
      // subtraction without and with borrow
      add_step("sub_72", "7", 0, 1'b0, 5'h12);
      add_step("sub_72", "2", 0, 1'b0, 5'h12);
      add_step("sub_72", "-", 2, 1'b0, 5'h15);
      add_step("sub_27", "2", 0, 1'b0, 5'h15);
      add_step("sub_27", "7", 0, 1'b0, 5'h15);
      add_step("sub_27", "-", 2, 1'b0, 5'h0B);
      // parser recovery
      add_step("recover", "4", 0, 1'b0, 5'h0B);
      add_step("recover", "x", 0, 1'b0, 5'h0B);  // non-digit as r2
      add_step("recover", "6", 0, 1'b0, 5'h0B);
      add_step("recover", "1", 0, 1'b0, 5'h0B);
      add_step("recover", "+", 2, 1'b0, 5'h07);
      add_step("no_op", "8", 0, 1'b0, 5'h07);
      add_step("no_op", "3", 0, 1'b0, 5'h07);
      add_step("no_op", "*", 2, 1'b0, 5'h07);    // not an operator
      add_step("no_op", "a", 0, 1'b0, 5'h07);
      // esc mid-triplet
      add_step("esc_mid", "6", 0, 1'b0, 5'h07);
      add_step("esc_mid", calc_pkg::CHAR_ESC, 0, 1'b0, 5'h00);
      add_step("after_esc", "2", 0, 1'b0, 5'h00);
      add_step("after_esc", "3", 0, 1'b0, 5'h00);
      add_step("after_esc", "+", 2, 1'b0, 5'h05);
      // back-pressure on the operator
      add_step("stall_sub", "9", 0, 1'b0, 5'h05);
      add_step("stall_sub", "4", 0, 1'b0, 5'h05);
      add_step("stall_sub", "-", 2, 1'b1, 5'h15);
      add_step("stall_add", "8", 0, 1'b0, 5'h15);
      add_step("stall_add", "8", 0, 1'b0, 5'h15);
      add_step("stall_add", "+", 2, 1'b1, 5'h10);
      // led source selection
      add_step("led_sel", "7", 0, 1'b0, 5'h10);
      add_step("led_sel", "3", 0, 1'b0, 5'h10);
      add_step("led_sel", "+", 2, 1'b0, 5'h0A);
      add_step("led_cr", calc_pkg::CHAR_CR, 0, 1'b0, 5'h07);
      add_step("led_del", calc_pkg::CHAR_DEL, 0, 1'b0, 5'h03);
      add_step("led_other", "!", 0, 1'b0, 5'h0A);
      add_step("led_cr2", calc_pkg::CHAR_CR, 0, 1'b0, 5'h07);
      add_step("led_esc", calc_pkg::CHAR_ESC, 0, 1'b0, 5'h00);
      limit = tab_byte.size() * 16 + 100;

      repeat (4) @(posedge CLKOP);
      i_rst <= 1'b0;
      for (int i = 0; i < tab_byte.size(); i++) apply_step(i);

      if (exp_q.size() != 0) begin
         fail_text($sformatf("%0d expected tx bytes were never sent", exp_q.size()));
      end else begin
         $display("No errors");
         $finish;
      end
   end

endmodule

// ==== hdl/calc_pkg.sv ====
// ----------------------------------------------------------
// serial calculator shared definitions
// widths, character codes and the parser state type
// ----------------------------------------------------------
package calc_pkg;

   // ----------------------------------------------------------
   // widths with a meaning
   // ----------------------------------------------------------
   typedef logic [7:0] byte_t;      // one uart character
   typedef logic [3:0] nibble_t;    // operand field, low nibble of a digit
   typedef logic [4:0] result_t;    // carry/borrow-out on top of 4-bit sum
   typedef logic [4:0] led_t;       // five board leds

   // ----------------------------------------------------------
   // character codes
   // ----------------------------------------------------------
   // soft reset from the host
   localparam byte_t CHAR_ESC   = 8'h1B;

   // operators, third character of a triplet
   localparam byte_t CHAR_PLUS  = 8'h2B;   // '+'
   localparam byte_t CHAR_MINUS = 8'h2D;   // '-'

   // led source selectors
   localparam byte_t CHAR_CR    = 8'h0D;   // show operand 1
   localparam byte_t CHAR_DEL   = 8'h7F;   // show operand 2

   // upper nibble of an operand character, '0' .. '?'
   localparam logic [3:0] DIGIT_CLASS = 4'h3;

   // result goes back as '@' .. '_'
   localparam byte_t RESULT_BASE = 8'h40;

   // ----------------------------------------------------------
   // parser states
   // ----------------------------------------------------------
   typedef enum logic [1:0] {
      WAIT_R1,    // waiting for first digit
      WAIT_R2,    // waiting for second digit
      WAIT_OP     // waiting for '+' or '-'
   } parse_state_t;

endpackage

// ==== hdl/cmd_parser.sv ====
// ----------------------------------------------------------
// command parser FSM
// collects two digit operands and an operator,
// then strobes the alu with add or subtract
// ----------------------------------------------------------
`timescale 1ns/1ps

module cmd_parser (
   input  logic              CLKOP,
   input  logic              i_rst,
   input  calc_pkg::byte_t   i_byte,
   input  logic              i_byte_valid,
   input  logic              i_esc_clear,
   output calc_pkg::nibble_t o_r1,
   output calc_pkg::nibble_t o_r2,
   output logic              o_sub,
   output logic              o_start
);

   calc_pkg::parse_state_t state;

   logic is_digit;
   logic is_plus;
   logic is_minus;

   // character classes
   assign is_digit = (i_byte[7:4] == calc_pkg::DIGIT_CLASS);   // 0x30..0x3f
   assign is_plus  = (i_byte == calc_pkg::CHAR_PLUS);
   assign is_minus = (i_byte == calc_pkg::CHAR_MINUS);

   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         state   <= calc_pkg::WAIT_R1;
         o_r1    <= '0;
         o_r2    <= '0;
         o_sub   <= 1'b0;
         o_start <= 1'b0;
      end else begin
         o_start <= 1'b0;                    // pulse by default
         if (i_esc_clear) begin
            // soft reset, drop partial operands
            state <= calc_pkg::WAIT_R1;
            o_r1  <= '0;
            o_r2  <= '0;
         end else if (i_byte_valid) begin
            case (state)
               calc_pkg::WAIT_R1: begin
                  if (is_digit) begin
                     o_r1  <= i_byte[3:0];   // low nibble only
                     state <= calc_pkg::WAIT_R2;
                  end
               end
               calc_pkg::WAIT_R2: begin
                  if (is_digit) begin
                     o_r2  <= i_byte[3:0];
                     state <= calc_pkg::WAIT_OP;
                  end else begin
                     state <= calc_pkg::WAIT_R1;   // restart collection
                  end
               end
               calc_pkg::WAIT_OP: begin
                  if (is_plus || is_minus) begin
                     o_sub   <= is_minus;
                     o_start <= 1'b1;
                  end
                  state <= calc_pkg::WAIT_R1;      // any third byte ends triplet
               end
               default: state <= calc_pkg::WAIT_R1;
            endcase
         end
      end
   end

endmodule

// ==== hdl/led_select.sv ====
// ----------------------------------------------------------
// led source select
// last received character picks operand 1, operand 2 or result
// ----------------------------------------------------------
`timescale 1ns/1ps

module led_select (
   input  logic              CLKOP,
   input  logic              i_rst,
   input  calc_pkg::byte_t   i_byte,
   input  logic              i_byte_valid,
   input  logic              i_esc_clear,
   input  calc_pkg::nibble_t i_r1,
   input  calc_pkg::nibble_t i_r2,
   input  calc_pkg::result_t i_result,
   output calc_pkg::led_t    o_led
);

   logic sel_cr;     // last byte was CR
   logic sel_del;    // last byte was DEL

   always_ff @(posedge CLKOP) begin
      if (i_rst || i_esc_clear) begin
         sel_cr  <= 1'b0;                    // back to result
         sel_del <= 1'b0;
      end else if (i_byte_valid) begin
         sel_cr  <= (i_byte == calc_pkg::CHAR_CR);
         sel_del <= (i_byte == calc_pkg::CHAR_DEL);
      end
   end

   // operands shown with a zero top bit
   assign o_led = sel_cr  ? {1'b0, i_r1} :
                  sel_del ? {1'b0, i_r2} :
                            i_result;

endmodule

// ==== hdl/nibble_alu.sv ====
// ----------------------------------------------------------
// nibble alu
// 4-bit add or two's complement subtract with carry out,
// registered with a one-cycle ready pulse
// ----------------------------------------------------------
`timescale 1ns/1ps

module nibble_alu (
   input  logic              CLKOP,
   input  logic              i_rst,
   input  calc_pkg::nibble_t i_r1,
   input  calc_pkg::nibble_t i_r2,
   input  logic              i_sub,
   input  logic              i_start,
   input  logic              i_esc_clear,
   output calc_pkg::result_t o_result,
   output logic              o_result_valid
);

   calc_pkg::nibble_t b_op;
   calc_pkg::result_t sum;

   // subtract as r1 + ~r2 + 1, carry set when r1 >= r2
   assign b_op = i_sub ? ~i_r2 : i_r2;
   assign sum  = {1'b0, i_r1} + {1'b0, b_op} + {4'b0000, i_sub};

   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         o_result       <= '0;
         o_result_valid <= 1'b0;
      end else begin
         o_result_valid <= i_start;          // ready one cycle after start
         if (i_esc_clear) o_result <= '0;    // led shows zeroed result
         else if (i_start) o_result <= sum;
      end
   end

endmodule

// ==== hdl/rx_capture.sv ====
// ----------------------------------------------------------
// receive capture
// latches each strobed byte, splits ESC from data bytes
// ----------------------------------------------------------
`timescale 1ns/1ps

module rx_capture (
   input  logic            CLKOP,
   input  logic            i_rst,
   input  calc_pkg::byte_t i_rx_data,
   input  logic            i_rx_valid,
   output calc_pkg::byte_t o_byte,
   output logic            o_byte_valid,
   output logic            o_esc_clear
);

   logic is_esc;

   assign is_esc = (i_rx_data == calc_pkg::CHAR_ESC);  // only ESC decode in design

   // byte register, payload only
   always_ff @(posedge CLKOP) begin
      if (i_rx_valid) o_byte <= i_rx_data;
   end

   // one-cycle strobes
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         o_byte_valid <= 1'b0;
         o_esc_clear  <= 1'b0;
      end else begin
         o_byte_valid <= i_rx_valid & ~is_esc;   // echoed and parsed
         o_esc_clear  <= i_rx_valid &  is_esc;   // soft clear
      end
   end

endmodule

// ==== hdl/serial_calc_top.sv ====
// ----------------------------------------------------------
// serial calculator top level
// byte strobes in, echo and result characters out, led view
// ----------------------------------------------------------
`timescale 1ns/1ps

module serial_calc_top (
   input  logic            CLKOP,
   input  logic            i_rst,
   input  calc_pkg::byte_t i_rx_data,
   input  logic            i_rx_valid,
   input  logic            i_tx_ready,
   output calc_pkg::byte_t o_tx_data,
   output logic            o_tx_valid,
   output calc_pkg::led_t  o_led
);

   calc_pkg::byte_t   byte_q;
   logic              byte_valid;
   logic              esc_clear;
   calc_pkg::nibble_t r1;
   calc_pkg::nibble_t r2;
   logic              sub;
   logic              start;
   calc_pkg::result_t result;
   logic              result_valid;

   rx_capture u_rx_capture (
      .CLKOP        (CLKOP),
      .i_rst        (i_rst),
      .i_rx_data    (i_rx_data),
      .i_rx_valid   (i_rx_valid),
      .o_byte       (byte_q),
      .o_byte_valid (byte_valid),
      .o_esc_clear  (esc_clear)
   );

   cmd_parser u_cmd_parser (
      .CLKOP        (CLKOP),
      .i_rst        (i_rst),
      .i_byte       (byte_q),
      .i_byte_valid (byte_valid),
      .i_esc_clear  (esc_clear),
      .o_r1         (r1),
      .o_r2         (r2),
      .o_sub        (sub),
      .o_start      (start)
   );

   nibble_alu u_nibble_alu (
      .CLKOP          (CLKOP),
      .i_rst          (i_rst),
      .i_r1           (r1),
      .i_r2           (r2),
      .i_sub          (sub),
      .i_start        (start),
      .i_esc_clear    (esc_clear),
      .o_result       (result),
      .o_result_valid (result_valid)
   );

   tx_arbiter u_tx_arbiter (
      .CLKOP          (CLKOP),
      .i_rst          (i_rst),
      .i_echo         (byte_q),
      .i_echo_valid   (byte_valid),
      .i_result       (result),
      .i_result_valid (result_valid),
      .i_tx_ready     (i_tx_ready),
      .o_tx_data      (o_tx_data),
      .o_tx_valid     (o_tx_valid)
   );

   led_select u_led_select (
      .CLKOP        (CLKOP),
      .i_rst        (i_rst),
      .i_byte       (byte_q),
      .i_byte_valid (byte_valid),
      .i_esc_clear  (esc_clear),
      .i_r1         (r1),
      .i_r2         (r2),
      .i_result     (result),
      .o_led        (o_led)
   );

endmodule

// ==== hdl/tx_arbiter.sv ====
// ----------------------------------------------------------
// transmit arbiter
// echo and result slots, one entry each, drained one byte
// per ready cycle with the echo going first
// ----------------------------------------------------------
`timescale 1ns/1ps

module tx_arbiter (
   input  logic              CLKOP,
   input  logic              i_rst,
   input  calc_pkg::byte_t   i_echo,
   input  logic              i_echo_valid,
   input  calc_pkg::result_t i_result,
   input  logic              i_result_valid,
   input  logic              i_tx_ready,
   output calc_pkg::byte_t   o_tx_data,
   output logic              o_tx_valid
);

   calc_pkg::byte_t echo_q;      // echo slot payload
   calc_pkg::byte_t res_q;       // result slot payload, already a character
   logic            echo_full;
   logic            res_full;
   logic            send_echo;
   logic            send_res;

   // ----------------------------------------------------------
   // slot select, echo has priority
   // ----------------------------------------------------------
   assign send_echo = i_tx_ready & echo_full;
   assign send_res  = i_tx_ready & ~echo_full & res_full;

   assign o_tx_valid = send_echo | send_res;
   assign o_tx_data  = echo_full ? echo_q : res_q;

   // payload, overwritten on each new byte
   always_ff @(posedge CLKOP) begin
      if (i_echo_valid)   echo_q <= i_echo;
      if (i_result_valid) res_q  <= calc_pkg::RESULT_BASE | {3'b000, i_result};  // '@' + result
   end

   // ----------------------------------------------------------
   // slot occupancy
   // ----------------------------------------------------------
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         echo_full <= 1'b0;
         res_full  <= 1'b0;
      end else begin
         // a new byte wins over the drain in the same cycle
         if (i_echo_valid)   echo_full <= 1'b1;
         else if (send_echo) echo_full <= 1'b0;

         if (i_result_valid) res_full <= 1'b1;
         else if (send_res)  res_full <= 1'b0;
      end
   end

endmodule

// ==== verilog.f ====
hdl/calc_pkg.sv
hdl/rx_capture.sv
hdl/cmd_parser.sv
hdl/nibble_alu.sv
hdl/tx_arbiter.sv
hdl/led_select.sv
hdl/serial_calc_top.sv
dv/tb_serial_calc.sv
